//--- Makefile
# Verilator build and run of the memory subsystem testbench

SIM := obj_dir/VmemSubsystemTb

$(SIM): all.f $(shell cat all.f)
	verilator --binary --timing --assert --top-module memSubsystemTb -f all.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- all.f
rtl/memPkg.sv
rtl/lsPkg.sv
rtl/dataCache.sv
rtl/instCache.sv
rtl/memArbiter.sv
rtl/memSubsystem.sv
bench/memModel.sv
bench/memSubsystemTb.sv

//--- bench/memModel.sv
// byte-addressed behavioral memory with fixed completion latency
`timescale 1ns/1ns

module memModel (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         memEn,
    input  logic                         memWrite,
    input  logic [lsPkg::lenWidth-1:0]   memLen,
    input  logic [memPkg::addrWidth-1:0] memAddr,
    input  logic [memPkg::dataWidth-1:0] memWdata,
    output logic                         memDone,
    output logic [memPkg::dataWidth-1:0] memRdata
);
    import memPkg::*;
    import lsPkg::*;

    logic [7:0]           storage [logic [addrWidth-1:0]];
    logic                 reqWrite;
    logic [lenWidth-1:0]  reqLen;
    logic [addrWidth-1:0] reqAddr;
    logic [dataWidth-1:0] reqWdata;

    // bytes never written read back as a fold of their whole address.
    function automatic logic [7:0] fillByte(input logic [addrWidth-1:0] a);
        return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h3c;
    endfunction

    initial begin
        int                   countdown;
        int                   i;
        logic                 complete;
        logic [addrWidth-1:0] a;
        memDone   = 1'b0;
        memRdata  = '0;
        countdown = 0;
        forever begin
            @(posedge clk);
            complete = 1'b0;
            if (rst) begin
                countdown = 0;
            end else if (memEn) begin
                reqWrite  = memWrite;
                reqLen    = memLen;
                reqAddr   = memAddr;
                reqWdata  = memWdata;
                countdown = 2;  // memDone rises 3 cycles after memEn.
            end else if (countdown > 0) begin
                countdown--;
                complete = (countdown == 0);
            end
            #1;
            memDone = complete;
            if (complete) begin
                for (i = 0; i < 4; i++) begin
                    a = reqAddr + 32'(i);  // unaligned start for uncached accesses.
                    if (reqWrite && i <= int'(reqLen)) begin
                        storage[a] = reqWdata[8*i +: 8];
                    end
                    memRdata[8*i +: 8] = storage.exists(a) ? storage[a] : fillByte(a);
                end
            end
        end
    end

endmodule

//--- bench/memSubsystemTb.sv
// testbench with clock, reset, shadow memory reference, check task and directed tests
`timescale 1ns/1ns

module memSubsystemTb;
    import memPkg::*;
    import lsPkg::*;

    localparam int timeoutCycles = 200;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 lsEn;
    logic                 lsWrite;
    logic [lenWidth-1:0]  lsLen;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] storeData;
    logic                 done;
    logic [dataWidth-1:0] loadData;
    logic                 fetchEn;
    logic [addrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [dataWidth-1:0] inst;
    logic                 memEn;
    logic                 memWrite;
    logic [lenWidth-1:0]  memLen;
    logic [addrWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWdata;
    logic                 memDone;
    logic [dataWidth-1:0] memRdata;

    logic [7:0]           shadow [logic [addrWidth-1:0]];
    logic [31:0]          lfsr = 32'h616a_ff2b;
    logic                 portWrite [$];  // requests seen on the memory port.
    logic [lenWidth-1:0]  portLen [$];
    logic [addrWidth-1:0] portAddr [$];
    logic [dataWidth-1:0] portData [$];

    memSubsystem memSubsystem_i (.*);
    memModel memModel_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (memEn) begin
            portWrite.push_back(memWrite);
            portLen.push_back(memLen);
            portAddr.push_back(memAddr);
            portData.push_back(memWdata);
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            abortRun($sformatf("FAIL %s: got %h, expected %h", name, got, want));
        end
    endtask

    function automatic logic [7:0] fillByte(input logic [addrWidth-1:0] a);
        return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h3c;
    endfunction

    // zero-extended load as the CPU should see it.
    function automatic logic [dataWidth-1:0] expectedLoad(
        input logic [addrWidth-1:0] a,
        input logic [lenWidth-1:0]  len
    );
        logic [dataWidth-1:0] word;
        int                   i;
        word = '0;
        for (i = 0; i <= int'(len); i++) begin
            word[8*i +: 8] = shadow.exists(a + 32'(i)) ? shadow[a + 32'(i)] : fillByte(a + 32'(i));
        end
        return word;
    endfunction

    // galois LFSR stepped once per bit.
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        int          n;
        value = '0;
        for (n = 0; n < count; n++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic logic [addrWidth-1:0] randomAddr();
        logic [addrWidth-1:0] a;
        a = randomBits(24);
        a[ioHi] = 1'b0;  // keeps it cacheable.
        return a;
    endfunction

    task automatic clearLog();
        portWrite.delete();
        portLen.delete();
        portAddr.delete();
        portData.delete();
    endtask

    task automatic access(
        input  logic                 write,
        input  logic [lenWidth-1:0]  len,
        input  logic [addrWidth-1:0] a,
        input  logic [dataWidth-1:0] data,
        output logic [dataWidth-1:0] result,
        output int                   cycles
    );
        int i;
        lsEn      = 1'b1;
        lsWrite   = write;
        lsLen     = len;
        addr      = a;
        storeData = data;
        cycles    = 0;
        do begin
            tick();
            lsEn = 1'b0;
            cycles++;
        end while (!done && cycles < timeoutCycles);
        if (!done) begin
            abortRun("timeout waiting for done on the data port");
        end
        result = loadData;
        if (write) begin
            for (i = 0; i <= int'(len); i++) begin
                shadow[a + 32'(i)] = data[8*i +: 8];
            end
        end
    endtask

    initial begin
        logic [addrWidth-1:0] a;
        logic [addrWidth-1:0] b;
        logic [addrWidth-1:0] f;
        logic [dataWidth-1:0] d;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] fetched;
        logic [lenWidth-1:0]  len;
        logic [addrWidth-1:0] stAddr [$];
        logic [lenWidth-1:0]  stLen [$];
        int                   cycles;
        int                   k;
        logic                 gotLoad;
        logic                 gotFetch;
        rst       = 1'b1;
        rdy       = 1'b1;
        lsEn      = 1'b0;
        lsWrite   = opRead;
        lsLen     = lenByte;
        addr      = '0;
        storeData = '0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // stores of every length and then a load of each.
        for (k = 0; k < 16; k++) begin
            case (k % 3)
                0:       len = lenByte;
                1:       len = lenHalf;
                default: len = lenWord;
            endcase
            a = randomAddr() & ~{30'b0, len};  // aligned to its length.
            stAddr.push_back(a);
            stLen.push_back(len);
            access(opWrite, len, a, randomBits(32), result, cycles);
        end
        foreach (stAddr[j]) begin
            access(opRead, stLen[j], stAddr[j], '0, result, cycles);
            checkValue("loadData", result, expectedLoad(stAddr[j], stLen[j]));
        end

        // second load of the same word hits.
        a = randomAddr() & ~32'h3;
        access(opRead, lenWord, a, '0, result, cycles);
        clearLog();
        access(opRead, lenWord, a, '0, result, cycles);
        checkValue("done latency", 32'(cycles), 32'd1);
        checkValue("memEn count", 32'(portAddr.size()), 32'd0);
        checkValue("loadData", result, expectedLoad(a, lenWord));

        // dirty victim goes out before the new word comes in.
        a = randomAddr() & ~32'h3;
        b = a ^ 32'h100;  // same index, other tag.
        d = randomBits(32);
        access(opWrite, lenWord, a, d, result, cycles);
        clearLog();
        access(opRead, lenWord, b, '0, result, cycles);
        checkValue("loadData", result, expectedLoad(b, lenWord));
        checkValue("memEn count", 32'(portAddr.size()), 32'd2);
        checkValue("memWrite", 32'(portWrite[0]), 32'd1);
        checkValue("memAddr", portAddr[0], a);
        checkValue("memWdata", portData[0], d);
        checkValue("memWrite", 32'(portWrite[1]), 32'd0);
        checkValue("memAddr", portAddr[1], b);
        access(opRead, lenWord, a, '0, result, cycles);
        checkValue("loadData", result, d);

        // I/O accesses always reach memory.
        a = randomAddr() | (32'h1 << ioHi) | (32'h1 << ioLo);
        a[1:0] = 2'b00;
        repeat (2) begin
            clearLog();
            access(opRead, lenWord, a, '0, result, cycles);
            checkValue("memEn count", 32'(portAddr.size()), 32'd1);
            checkValue("loadData", result, expectedLoad(a, lenWord));
        end
        clearLog();
        d = randomBits(32);
        access(opWrite, lenHalf, a + 32'h2, d, result, cycles);
        checkValue("memEn count", 32'(portAddr.size()), 32'd1);
        checkValue("memWrite", 32'(portWrite[0]), 32'd1);
        checkValue("memLen", 32'(portLen[0]), 32'(lenHalf));
        checkValue("memAddr", portAddr[0], a + 32'h2);
        checkValue("memWdata", portData[0], d);

        // fetch miss and data miss in the same cycle.
        a = randomAddr() & ~32'h3;
        access(opRead, lenWord, a ^ 32'h200, '0, result, cycles);  // leaves the line clean.
        f = randomBits(24) | 32'h4000_0000;
        f[ioHi] = 1'b0;
        f[1:0]  = 2'b00;
        clearLog();
        lsEn      = 1'b1;
        lsWrite   = opRead;
        lsLen     = lenWord;
        addr      = a;
        fetchEn   = 1'b1;
        fetchAddr = f;
        gotLoad   = 1'b0;
        gotFetch  = 1'b0;
        cycles    = 0;
        while (!(gotLoad && gotFetch) && cycles < timeoutCycles) begin
            tick();
            lsEn    = 1'b0;
            fetchEn = 1'b0;
            cycles++;
            if (done) begin
                gotLoad = 1'b1;
                result  = loadData;
            end
            if (fetchDone) begin
                gotFetch = 1'b1;
                fetched  = inst;
            end
        end
        if (!(gotLoad && gotFetch)) begin
            abortRun("timeout waiting for the load and the fetch to finish");
        end
        checkValue("loadData", result, expectedLoad(a, lenWord));
        checkValue("inst", fetched, expectedLoad(f, lenWord));
        checkValue("memEn count", 32'(portAddr.size()), 32'd2);
        checkValue("memAddr", portAddr[0], a);
        checkValue("memAddr", portAddr[1], f);

        // stall while the miss is outstanding.
        a = randomAddr() & ~32'h3;
        clearLog();
        lsEn    = 1'b1;
        lsWrite = opRead;
        lsLen   = lenWord;
        addr    = a;
        cycles  = 0;
        do begin
            tick();
            lsEn = 1'b0;
            cycles++;
        end while (portAddr.size() == 0 && cycles < timeoutCycles);
        if (portAddr.size() == 0) begin
            abortRun("timeout waiting for the miss to reach the memory port");
        end
        rdy = 1'b0;
        repeat (6) begin
            tick();
            checkValue("done", 32'(done), 32'd0);
        end
        rdy    = 1'b1;
        cycles = 0;
        while (!done && cycles < timeoutCycles) begin
            tick();
            cycles++;
        end
        if (!done) begin
            abortRun("timeout waiting for done after the stall");
        end
        checkValue("loadData", loadData, expectedLoad(a, lenWord));

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- rtl/dataCache.sv
// write-back data cache with miss FSM and byte lane insert and extract
`timescale 1ns/1ns

module dataCache (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         lsEn,
    input  logic                         lsWrite,
    input  logic [lsPkg::lenWidth-1:0]   lsLen,
    input  logic [memPkg::addrWidth-1:0] addr,
    input  logic [memPkg::dataWidth-1:0] storeData,
    input  logic                         dDone,
    input  logic [memPkg::dataWidth-1:0] dRdata,
    output logic                         done,
    output logic [memPkg::dataWidth-1:0] loadData,
    output logic                         dReq,
    output logic                         dWrite,
    output logic [lsPkg::lenWidth-1:0]   dLen,
    output logic [memPkg::addrWidth-1:0] dAddr,
    output logic [memPkg::dataWidth-1:0] dWdata
);
    import memPkg::*;
    import lsPkg::*;

    typedef enum logic [1:0] {idle, writeBack, fill, bypass} stateType;

    stateType state;

    logic [dataWidth-1:0] lineData [lineCount];
    logic [tagWidth-1:0]  lineTag  [lineCount];
    logic [lineCount-1:0] validBits;
    logic [lineCount-1:0] dirtyBits;

    logic                 reqWrite;  // request kept across a miss.
    logic [lenWidth-1:0]  reqLen;
    logic [addrWidth-1:0] reqAddr;

    logic [indexWidth-1:0] index;
    logic [indexWidth-1:0] reqIndex;
    logic [tagWidth-1:0]   tag;
    logic [indexLo-1:0]    offset;
    logic [addrWidth-1:0]  victimAddr;
    logic                  isIo;
    logic                  hit;
    logic                  allocStore;

    assign index      = addr[tagLo-1:indexLo];
    assign tag        = addr[addrWidth-1:tagLo];
    assign offset     = addr[indexLo-1:0];
    assign reqIndex   = reqAddr[tagLo-1:indexLo];
    assign victimAddr = {lineTag[index], index, {indexLo{1'b0}}};
    assign isIo       = addr[ioHi] & addr[ioLo];
    assign hit        = validBits[index] && (lineTag[index] == tag) && !isIo;
    assign allocStore = lsWrite && !isIo && (hit || lsLen == lenWord);

    function automatic logic [dataWidth-1:0] laneMask(input logic [lenWidth-1:0] len);
        case (len)
            lenByte: return {{(dataWidth-8){1'b0}}, 8'hff};
            lenHalf: return {{(dataWidth-16){1'b0}}, 16'hffff};
            default: return '1;
        endcase
    endfunction

    function automatic logic [dataWidth-1:0] extractLane(
        input logic [dataWidth-1:0] word,
        input logic [indexLo-1:0]   off,
        input logic [lenWidth-1:0]  len
    );
        return (word >> {off, 3'b000}) & laneMask(len);  // zero-extended.
    endfunction

    function automatic logic [dataWidth-1:0] insertLane(
        input logic [dataWidth-1:0] old,
        input logic [dataWidth-1:0] data,
        input logic [indexLo-1:0]   off,
        input logic [lenWidth-1:0]  len
    );
        logic [dataWidth-1:0] mask;
        mask = laneMask(len) << {off, 3'b000};
        return (old & ~mask) | ((data << {off, 3'b000}) & mask);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            done      <= 1'b0;
            dReq      <= 1'b0;
            validBits <= '0;
            dirtyBits <= '0;
        end else if (rdy) begin
            done <= 1'b0;
            dReq <= 1'b0;
            case (state)
                idle: begin
                    if (lsEn) begin
                        reqWrite <= lsWrite;
                        reqLen   <= lsLen;
                        reqAddr  <= addr;
                        if (allocStore) begin
                            validBits[index] <= 1'b1;
                            dirtyBits[index] <= 1'b1;
                        end
                        if (!lsWrite && hit) begin
                            done     <= 1'b1;
                            loadData <= extractLane(lineData[index], offset, lsLen);
                        end else if (allocStore && (hit || !dirtyBits[index])) begin
                            done <= 1'b1;  // no victim to save.
                        end else if (isIo || lsWrite && !allocStore) begin
                            dReq   <= 1'b1;  // uncached access as issued.
                            dWrite <= lsWrite;
                            dLen   <= lsLen;
                            dAddr  <= addr;
                            dWdata <= storeData;
                            state  <= bypass;
                        end else if (dirtyBits[index]) begin
                            dReq   <= 1'b1;  // old word goes out first.
                            dWrite <= opWrite;
                            dLen   <= lenWord;
                            dAddr  <= victimAddr;
                            dWdata <= lineData[index];
                            state  <= writeBack;
                        end else begin
                            dReq   <= 1'b1;
                            dWrite <= opRead;
                            dLen   <= lenWord;
                            dAddr  <= {addr[addrWidth-1:indexLo], {indexLo{1'b0}}};
                            state  <= fill;
                        end
                    end
                end
                writeBack: begin
                    if (dDone) begin
                        if (reqWrite) begin
                            done  <= 1'b1;  // store data is already in the line.
                            state <= idle;
                        end else begin
                            dReq   <= 1'b1;
                            dWrite <= opRead;
                            dLen   <= lenWord;
                            dAddr  <= {reqAddr[addrWidth-1:indexLo], {indexLo{1'b0}}};
                            state  <= fill;
                        end
                    end
                end
                fill: begin
                    if (dDone) begin
                        validBits[reqIndex] <= 1'b1;
                        dirtyBits[reqIndex] <= 1'b0;
                        loadData <= extractLane(dRdata, reqAddr[indexLo-1:0], reqLen);
                        done     <= 1'b1;
                        state    <= idle;
                    end
                end
                default: begin
                    if (dDone) begin
                        if (!reqWrite) begin
                            loadData <= extractLane(dRdata, '0, reqLen);
                        end
                        done  <= 1'b1;
                        state <= idle;
                    end
                end
            endcase
        end
    end

    // line storage, written on an allocating store or a finished fill.
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == idle && lsEn && allocStore) begin
                lineTag[index]  <= tag;
                lineData[index] <= insertLane(lineData[index], storeData, offset, lsLen);
            end else if (state == fill && dDone) begin
                lineTag[reqIndex]  <= reqAddr[addrWidth-1:tagLo];
                lineData[reqIndex] <= dRdata;
            end
        end
    end

    // the CPU waits for done before it sends the next request.
    assert property (@(posedge clk) disable iff (rst) (rdy && lsEn) |-> state == idle);

    // every memory completion belongs to a miss in flight.
    assert property (@(posedge clk) disable iff (rst) dDone |-> state != idle);

endmodule

//--- rtl/instCache.sv
// read-only instruction cache with fill on miss
`timescale 1ns/1ns

module instCache (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         fetchEn,
    input  logic [memPkg::addrWidth-1:0] fetchAddr,
    input  logic                         iDone,
    input  logic [memPkg::dataWidth-1:0] iRdata,
    output logic                         fetchDone,
    output logic [memPkg::dataWidth-1:0] inst,
    output logic                         iReq,
    output logic [memPkg::addrWidth-1:0] iAddr
);
    import memPkg::*;

    logic [dataWidth-1:0] lineData [lineCount];
    logic [tagWidth-1:0]  lineTag  [lineCount];
    logic [lineCount-1:0] validBits;
    logic                 pending;  // a miss read is out.

    logic [indexWidth-1:0] index;
    logic [indexWidth-1:0] fillIndex;
    logic                  hit;
    logic                  fillLine;

    assign index     = fetchAddr[tagLo-1:indexLo];
    assign fillIndex = iAddr[tagLo-1:indexLo];
    assign hit       = validBits[index] && (lineTag[index] == fetchAddr[addrWidth-1:tagLo])
                       && !(fetchAddr[ioHi] & fetchAddr[ioLo]);
    assign fillLine  = pending && iDone && !(iAddr[ioHi] & iAddr[ioLo]);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            fetchDone <= 1'b0;
            iReq      <= 1'b0;
            validBits <= '0;
        end else if (rdy) begin
            fetchDone <= 1'b0;
            iReq      <= 1'b0;
            if (pending) begin
                if (iDone) begin
                    pending   <= 1'b0;
                    fetchDone <= 1'b1;
                    inst      <= iRdata;
                    if (fillLine) begin
                        validBits[fillIndex] <= 1'b1;
                    end
                end
            end else if (fetchEn) begin
                if (hit) begin
                    fetchDone <= 1'b1;
                    inst      <= lineData[index];
                end else begin
                    pending <= 1'b1;
                    iReq    <= 1'b1;
                    iAddr   <= fetchAddr;  // held until the fill returns.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && fillLine) begin
            lineTag[fillIndex]  <= iAddr[addrWidth-1:tagLo];
            lineData[fillIndex] <= iRdata;
        end
    end

    // the fetch unit waits for fetchDone before the next fetch.
    assert property (@(posedge clk) disable iff (rst) (rdy && fetchEn) |-> !pending);

endmodule

//--- rtl/lsPkg.sv
// access length encoding and memory operation codes
package lsPkg;

    // access length, coded as byte count minus one.
    localparam int lenWidth = 2;

    localparam logic [lenWidth-1:0] lenByte = 2'd0;
    localparam logic [lenWidth-1:0] lenHalf = 2'd1;
    localparam logic [lenWidth-1:0] lenWord = 2'd3;

    // memory operation on the request ports.
    localparam logic opRead  = 1'b0;
    localparam logic opWrite = 1'b1;

endpackage

//--- rtl/memArbiter.sv
// two-client memory arbiter with completion routing and stall holding
`timescale 1ns/1ns

module memArbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         dReq,
    input  logic                         dWrite,
    input  logic [lsPkg::lenWidth-1:0]   dLen,
    input  logic [memPkg::addrWidth-1:0] dAddr,
    input  logic [memPkg::dataWidth-1:0] dWdata,
    input  logic                         iReq,
    input  logic [memPkg::addrWidth-1:0] iAddr,
    input  logic                         memDone,
    input  logic [memPkg::dataWidth-1:0] memRdata,
    output logic                         dDone,
    output logic [memPkg::dataWidth-1:0] dRdata,
    output logic                         iDone,
    output logic [memPkg::dataWidth-1:0] iRdata,
    output logic                         memEn,
    output logic                         memWrite,
    output logic [lsPkg::lenWidth-1:0]   memLen,
    output logic [memPkg::addrWidth-1:0] memAddr,
    output logic [memPkg::dataWidth-1:0] memWdata
);
    import memPkg::*;
    import lsPkg::*;

    logic                 dPend;
    logic                 dPendWrite;
    logic [lenWidth-1:0]  dPendLen;
    logic [addrWidth-1:0] dPendAddr;
    logic [dataWidth-1:0] dPendWdata;
    logic                 iPend;
    logic [addrWidth-1:0] iPendAddr;

    logic                 busy;       // one request on the port.
    logic                 ownerInst;  // owner of that request.
    logic                 doneHeld;   // completion seen during a stall.
    logic [dataWidth-1:0] heldRdata;

    logic                 grantD;
    logic                 grantI;
    logic                 finish;
    logic [dataWidth-1:0] finishData;

    assign grantD     = !busy && (dReq || dPend);
    assign grantI     = !busy && !grantD && (iReq || iPend);
    assign finish     = memDone || doneHeld;
    assign finishData = doneHeld ? heldRdata : memRdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            memEn    <= 1'b0;
            dDone    <= 1'b0;
            iDone    <= 1'b0;
            dPend    <= 1'b0;
            iPend    <= 1'b0;
            doneHeld <= 1'b0;
        end else begin
            memEn <= rdy && (grantD || grantI);  // memory side runs through stalls.
            if (!rdy && memDone) begin
                doneHeld  <= 1'b1;
                heldRdata <= memRdata;
            end
            if (rdy) begin
                dDone <= 1'b0;
                iDone <= 1'b0;
                if (finish) begin
                    busy     <= 1'b0;
                    doneHeld <= 1'b0;
                    dDone    <= !ownerInst;
                    iDone    <= ownerInst;
                    if (ownerInst) begin
                        iRdata <= finishData;
                    end else begin
                        dRdata <= finishData;
                    end
                end
                if (dReq) begin
                    dPendWrite <= dWrite;
                    dPendLen   <= dLen;
                    dPendAddr  <= dAddr;
                    dPendWdata <= dWdata;
                end
                if (iReq) begin
                    iPendAddr <= iAddr;
                end
                dPend <= (dPend || dReq) && !grantD;
                iPend <= (iPend || iReq) && !grantI;
                if (grantD) begin
                    busy      <= 1'b1;
                    ownerInst <= 1'b0;
                    memWrite  <= dReq ? dWrite : dPendWrite;
                    memLen    <= dReq ? dLen : dPendLen;
                    memAddr   <= dReq ? dAddr : dPendAddr;
                    memWdata  <= dReq ? dWdata : dPendWdata;
                end else if (grantI) begin
                    busy      <= 1'b1;
                    ownerInst <= 1'b1;
                    memWrite  <= opRead;
                    memLen    <= lenWord;
                    memAddr   <= iReq ? iAddr : iPendAddr;
                    memWdata  <= '0;
                end
            end
        end
    end

    // the memory answers only the request in flight.
    assert property (@(posedge clk) disable iff (rst) memDone |-> busy);

endmodule

//--- rtl/memPkg.sv
// address, data and cache geometry constants plus the I/O region rule
package memPkg;

    // bus widths.
    localparam int addrWidth = 32;
    localparam int dataWidth = 32;

    // direct-mapped geometry, one word per line.
    localparam int indexWidth = 6;
    localparam int lineCount  = 1 << indexWidth;  // 64 lines.

    // address split: tag 31:8, index 7:2, byte offset 1:0.
    localparam int indexLo  = 2;                     // lowest index bit.
    localparam int tagLo    = indexLo + indexWidth;  // lowest tag bit.
    localparam int tagWidth = addrWidth - tagLo;     // 24 bits.

    // I/O region is every address with both of these bits set.
    // Such accesses go straight to memory and never fill a line.
    localparam int ioHi = 17;
    localparam int ioLo = 16;

endpackage

//--- rtl/memSubsystem.sv
// memory subsystem top level with data cache, instruction cache and arbiter
`timescale 1ns/1ns

module memSubsystem (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         lsEn,
    input  logic                         lsWrite,
    input  logic [lsPkg::lenWidth-1:0]   lsLen,
    input  logic [memPkg::addrWidth-1:0] addr,
    input  logic [memPkg::dataWidth-1:0] storeData,
    output logic                         done,
    output logic [memPkg::dataWidth-1:0] loadData,
    input  logic                         fetchEn,
    input  logic [memPkg::addrWidth-1:0] fetchAddr,
    output logic                         fetchDone,
    output logic [memPkg::dataWidth-1:0] inst,
    output logic                         memEn,
    output logic                         memWrite,
    output logic [lsPkg::lenWidth-1:0]   memLen,
    output logic [memPkg::addrWidth-1:0] memAddr,
    output logic [memPkg::dataWidth-1:0] memWdata,
    input  logic                         memDone,
    input  logic [memPkg::dataWidth-1:0] memRdata
);
    import memPkg::*;
    import lsPkg::*;

    // data cache miss traffic.
    logic                 dReq;
    logic                 dWrite;
    logic [lenWidth-1:0]  dLen;
    logic [addrWidth-1:0] dAddr;
    logic [dataWidth-1:0] dWdata;
    logic                 dDone;
    logic [dataWidth-1:0] dRdata;

    // instruction cache miss traffic.
    logic                 iReq;
    logic [addrWidth-1:0] iAddr;
    logic                 iDone;
    logic [dataWidth-1:0] iRdata;

    dataCache dataCache_i (
        .clk, .rst, .rdy,
        .lsEn, .lsWrite, .lsLen, .addr, .storeData,
        .dDone, .dRdata,
        .done, .loadData,
        .dReq, .dWrite, .dLen, .dAddr, .dWdata
    );

    instCache instCache_i (
        .clk, .rst, .rdy,
        .fetchEn, .fetchAddr, .iDone, .iRdata,
        .fetchDone, .inst, .iReq, .iAddr
    );

    memArbiter memArbiter_i (
        .clk, .rst, .rdy,
        .dReq, .dWrite, .dLen, .dAddr, .dWdata,
        .iReq, .iAddr,
        .memDone, .memRdata,
        .dDone, .dRdata, .iDone, .iRdata,
        .memEn, .memWrite, .memLen, .memAddr, .memWdata
    );

endmodule
